// ==== exe_cfg.svh ====
`ifndef EXE_CFG_SVH
`define EXE_CFG_SVH

// datapath word
`define EXE_DATA_W 32

// raw micro-op coming from decode
`define EXE_UOP_W 16

// architectural register index
`define EXE_REG_W 5

// andi r0, r0, 0
`define EXE_INST_NOP 32'h0340_0000

`endif

// ==== isa_pkg.sv ====
`default_nettype none

`include "exe_cfg.svh"

package isa_pkg;

    typedef logic [`EXE_DATA_W-1:0]   word_t;
    typedef logic [2*`EXE_DATA_W-1:0] dword_t;
    typedef logic [31:0]              inst_t;
    typedef logic [`EXE_REG_W-1:0]    reg_addr_t;
    typedef logic [`EXE_UOP_W-1:0]    uop_t;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_sll    = 4'd5,
        alu_srl    = 4'd6,
        alu_slt    = 4'd7,
        alu_mul_lo = 4'd8,
        alu_mul_hi = 4'd9
    } alu_op_t;

    typedef enum logic [1:0] {
        mem_byte = 2'd0,
        mem_half = 2'd1,
        mem_word = 2'd2
    } mem_size_t;

    typedef enum logic [2:0] {
        trap_none     = 3'd0,
        trap_syscall  = 3'd1,
        trap_brk      = 3'd2,
        trap_misalign = 3'd3
    } trap_t;

    // field view of uop_t with op in the low nibble
    typedef struct packed {
        logic [3:0] rsvd;
        logic       wb_en;
        logic       brk;
        logic       syscall;
        logic       atomic;
        mem_size_t  size;
        logic       store;
        logic       mem_en;
        alu_op_t    op;
    } uop_fields_t;

endpackage

`default_nettype wire

// ==== pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    // instruction entering execute-0
    typedef struct packed {
        word_t     pc;
        inst_t     inst;
        uop_t      uop;
        word_t     rj_data;
        word_t     rk_data;
        word_t     imm;
        reg_addr_t rd;
        trap_t     trap;
    } issue_t;

    // contents of the execute-0 to execute-1 buffer
    typedef struct packed {
        word_t     pc;
        inst_t     inst;
        reg_addr_t rd;
        logic      wb_en;
        alu_op_t   op;
        word_t     alu_result;
        word_t     pp_hh;
        word_t     pp_hl;
        word_t     pp_lh;
        word_t     pp_ll;
        word_t     mul_comp;
        trap_t     trap;
    } ex1_t;

    // op is 1 for a store
    typedef struct packed {
        logic       op;
        logic [3:0] byte_en;
        logic       atomic;
        word_t      addr;
    } dcache_req_t;

    typedef struct packed {
        word_t     pc;
        reg_addr_t rd;
        word_t     data;
        logic      wb_en;
        trap_t     trap;
    } wb_t;

endpackage

`default_nettype wire

// ==== exe_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_decode (
    input  isa_pkg::uop_t   uop,
    input  logic [1:0]      pc_low,
    output isa_pkg::alu_op_t alu_op,
    output logic            mem_en,
    output logic            store,
    output logic [3:0]      byte_en,
    output logic            atomic,
    output logic            wb_en,
    output isa_pkg::trap_t  trap
);

    import isa_pkg::*;

    uop_fields_t f;
    logic [3:0]  be_base;
    logic        misalign;

    assign f      = uop_fields_t'(uop);
    assign alu_op = f.op;
    assign mem_en = f.mem_en;
    assign store  = f.store;
    assign atomic = f.atomic;
    assign wb_en  = f.wb_en;

    // access size to lane mask shifted to the addressed byte
    always_comb begin
        case (f.size)
            mem_byte: be_base = 4'b0001;
            mem_half: be_base = 4'b0011;
            default:  be_base = 4'b1111;
        endcase
    end

    assign byte_en = be_base << pc_low;

    always_comb begin
        misalign = 1'b0;
        if (f.mem_en) begin
            case (f.size)
                mem_half: misalign = pc_low[0];
                mem_word: misalign = |pc_low;
                default:  misalign = 1'b0;
            endcase
        end
    end

    // syscall beats break beats misalign
    always_comb begin
        if (f.syscall) begin
            trap = trap_syscall;
        end else if (f.brk) begin
            trap = trap_brk;
        end else if (misalign) begin
            trap = trap_misalign;
        end else begin
            trap = trap_none;
        end
    end

endmodule

`default_nettype wire

// ==== exe_stage0.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_stage0 (
    input  pipe_pkg::issue_t      issue,
    input  logic                  issue_fire,
    output pipe_pkg::ex1_t        ex1_next,
    output pipe_pkg::dcache_req_t dcache_req,
    output logic                  dcache_valid
);

    import isa_pkg::*;

    alu_op_t    op;
    logic       mem_en;
    logic       store;
    logic [3:0] byte_en;
    logic       atomic;
    logic       wb_en;
    trap_t      dec_trap;
    word_t      addr;
    word_t      src_a;
    word_t      src_b;
    word_t      alu_res;

    assign addr = issue.rj_data + issue.imm;

    exe_decode u_decode (
        .uop     (issue.uop),
        .pc_low  (addr[1:0]),
        .alu_op  (op),
        .mem_en  (mem_en),
        .store   (store),
        .byte_en (byte_en),
        .atomic  (atomic),
        .wb_en   (wb_en),
        .trap    (dec_trap)
    );

    // memory ops add the immediate offset
    assign src_a = issue.rj_data;
    assign src_b = mem_en ? issue.imm : issue.rk_data;

    always_comb begin
        case (op)
            alu_add: alu_res = src_a + src_b;
            alu_sub: alu_res = src_a - src_b;
            alu_and: alu_res = src_a & src_b;
            alu_or:  alu_res = src_a | src_b;
            alu_xor: alu_res = src_a ^ src_b;
            alu_sll: alu_res = src_a << src_b[4:0];
            alu_srl: alu_res = src_a >> src_b[4:0];
            alu_slt: alu_res = word_t'($signed(src_a) < $signed(src_b));
            default: alu_res = '0;
        endcase
    end

    assign ex1_next.pc         = issue.pc;
    assign ex1_next.inst       = issue.inst;
    assign ex1_next.rd         = issue.rd;
    assign ex1_next.wb_en      = wb_en;
    assign ex1_next.op         = op;
    assign ex1_next.alu_result = alu_res;

    // unsigned 16x16 pieces summed in execute-1
    assign ex1_next.pp_hh = {16'b0, src_a[31:16]} * {16'b0, src_b[31:16]};
    assign ex1_next.pp_hl = {16'b0, src_a[31:16]} * {16'b0, src_b[15:0]};
    assign ex1_next.pp_lh = {16'b0, src_a[15:0]} * {16'b0, src_b[31:16]};
    assign ex1_next.pp_ll = {16'b0, src_a[15:0]} * {16'b0, src_b[15:0]};
    // taken off the high half to turn the unsigned product into a signed one
    assign ex1_next.mul_comp = (src_a[31] ? src_b : '0) + (src_b[31] ? src_a : '0);

    // earlier stages own the older trap
    assign ex1_next.trap = (issue.trap != trap_none) ? issue.trap : dec_trap;

    assign dcache_req.op      = store;
    assign dcache_req.byte_en = byte_en;
    assign dcache_req.atomic  = atomic;
    assign dcache_req.addr    = addr;
    assign dcache_valid       = issue_fire & mem_en;

endmodule

`default_nettype wire

// ==== exe_stage_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exe_cfg.svh"

module exe_stage_buffer (
    input  logic           clk,
    input  logic           aresetn,
    input  logic           flush,
    input  logic           ex0_valid,
    input  pipe_pkg::ex1_t ex1_next,
    input  logic           ex1_allowin,
    output logic           ex0_allowin,
    output logic           buf_valid,
    output pipe_pkg::ex1_t buf_data
);

    import isa_pkg::*;
    import pipe_pkg::*;

    typedef enum logic {
        run,
        trap_held
    } hold_state_t;

    hold_state_t hold_q;
    ex1_t        slot_q;
    logic        slot_valid_q;
    logic        slot_trap;
    logic        load;
    logic        drain;

    assign slot_trap = slot_valid_q & (slot_q.trap != trap_none);
    assign drain     = slot_valid_q & ex1_allowin;

    // a trap in the slot or behind us blocks new work until flush
    assign ex0_allowin = (~slot_valid_q | ex1_allowin) & ~slot_trap & (hold_q == run);
    assign load        = ex0_valid & ex0_allowin;

    always_ff @(posedge clk) begin
        if (!aresetn || flush) begin
            slot_valid_q <= 1'b0;
        end else if (load) begin
            slot_valid_q <= 1'b1;
        end else if (drain) begin
            slot_valid_q <= 1'b0;
        end
    end

    // an emptied slot holds a nop
    always_ff @(posedge clk) begin
        if (!aresetn || flush || (drain && !load)) begin
            slot_q      <= '0;
            slot_q.inst <= `EXE_INST_NOP;
        end else if (load) begin
            slot_q <= ex1_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn || flush) begin
            hold_q <= run;
        end else begin
            case (hold_q)
                run: begin
                    if (slot_trap) begin
                        hold_q <= trap_held;
                    end
                end
                default: hold_q <= trap_held;
            endcase
        end
    end

    assign buf_valid = slot_valid_q;
    assign buf_data  = slot_q;

endmodule

`default_nettype wire

// ==== exe_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_result (
    input  logic           buf_valid,
    input  pipe_pkg::ex1_t buf_data,
    input  logic           wb_allowin,
    output pipe_pkg::wb_t  wb,
    output logic           wb_valid,
    output logic           ex1_allowin
);

    import isa_pkg::*;

    dword_t prod_u;
    dword_t prod_s;
    word_t  wb_data;
    logic   trapped;

    // a*b from the four 16-bit pieces
    assign prod_u = {buf_data.pp_hh, 32'b0}
                  + {16'b0, buf_data.pp_hl, 16'b0}
                  + {16'b0, buf_data.pp_lh, 16'b0}
                  + {32'b0, buf_data.pp_ll};

    // only the high half changes for signed operands
    assign prod_s = prod_u - {buf_data.mul_comp, 32'b0};

    always_comb begin
        case (buf_data.op)
            alu_mul_lo: wb_data = prod_s[31:0];
            alu_mul_hi: wb_data = prod_s[63:32];
            default:    wb_data = buf_data.alu_result;
        endcase
    end

    assign trapped = (buf_data.trap != trap_none);

    assign wb.pc    = buf_data.pc;
    assign wb.rd    = buf_data.rd;
    assign wb.data  = wb_data;
    // trapped instructions must not touch the register file
    assign wb.wb_en = buf_data.wb_en & ~trapped;
    assign wb.trap  = buf_data.trap;

    assign wb_valid    = buf_valid;
    assign ex1_allowin = ~buf_valid | wb_allowin;

endmodule

`default_nettype wire

// ==== exe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_top (
    input  logic                  clk,
    input  logic                  aresetn,
    input  logic                  flush,
    input  logic                  issue_valid,
    input  pipe_pkg::issue_t      issue,
    output logic                  issue_allowin,
    output pipe_pkg::dcache_req_t dcache_req,
    output logic                  dcache_valid,
    output pipe_pkg::wb_t         wb,
    output logic                  wb_valid,
    input  logic                  wb_allowin
);

    import pipe_pkg::*;

    ex1_t ex1_next;
    ex1_t buf_data;
    logic ex0_readygo;
    logic ex0_valid;
    logic ex0_allowin;
    logic issue_fire;
    logic buf_valid;
    logic ex1_allowin;

    // no multicycle units in execute-0
    assign ex0_readygo   = 1'b1;
    assign ex0_valid     = issue_valid & ex0_readygo;
    assign issue_allowin = ex0_allowin;
    assign issue_fire    = ex0_valid & ex0_allowin;

    exe_stage0 u_stage0 (
        .issue        (issue),
        .issue_fire   (issue_fire),
        .ex1_next     (ex1_next),
        .dcache_req   (dcache_req),
        .dcache_valid (dcache_valid)
    );

    exe_stage_buffer u_buffer (
        .clk         (clk),
        .aresetn     (aresetn),
        .flush       (flush),
        .ex0_valid   (ex0_valid),
        .ex1_next    (ex1_next),
        .ex1_allowin (ex1_allowin),
        .ex0_allowin (ex0_allowin),
        .buf_valid   (buf_valid),
        .buf_data    (buf_data)
    );

    exe_result u_result (
        .buf_valid   (buf_valid),
        .buf_data    (buf_data),
        .wb_allowin  (wb_allowin),
        .wb          (wb),
        .wb_valid    (wb_valid),
        .ex1_allowin (ex1_allowin)
    );

endmodule

`default_nettype wire

// ==== tb_exe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exe_top;

    import isa_pkg::*;
    import pipe_pkg::*;

    // reset, alu, mul, mem with flushes, back-pressure, trap hold, flush
    localparam int test_cycles  = 6 + 16 * 3 + 12 * 3 + 9 * 5 + 10 + 10 + 4;
    localparam int limit_cycles = 2 * test_cycles;

    logic        clk;
    logic        aresetn;
    logic        flush;
    logic        issue_valid;
    issue_t      issue;
    logic        issue_allowin;
    dcache_req_t dcache_req;
    logic        dcache_valid;
    wb_t         wb;
    logic        wb_valid;
    logic        wb_allowin;

    logic [31:0] rng;
    int          cycles;
    int          checks;
    int          errors;
    int          test_errors;
    dcache_req_t req_seen;
    logic        req_valid_seen;

    exe_top uut (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit_cycles) begin
            $display("timeout: no result after %0d cycles, the DUT stopped moving", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] rand32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // op [3:0], mem_en 4, store 5, size [7:6], atomic 8, syscall 9, break 10, wb_en 11
    function automatic uop_t make_uop(input alu_op_t op, input logic mem, input logic st,
                                      input mem_size_t size, input logic atomic,
                                      input logic sys, input logic brk, input logic wb_en);
        return {4'b0, wb_en, brk, sys, atomic, size, st, mem, op};
    endfunction

    function automatic issue_t make_issue(input uop_t uop, input word_t rj, input word_t rk,
                                          input word_t imm);
        issue_t      ins;
        logic [31:0] r;
        r           = rand32();
        ins.pc      = {r[31:2], 2'b00};
        ins.rd      = r[4:0];
        ins.inst    = rand32();
        ins.uop     = uop;
        ins.rj_data = rj;
        ins.rk_data = rk;
        ins.imm     = imm;
        ins.trap    = trap_none;
        return ins;
    endfunction

    // expected writeback and dcache request
    task automatic model(input issue_t ins, output wb_t w, output dcache_req_t r);
        alu_op_t            op;
        word_t              b;
        word_t              addr;
        logic signed [63:0] prod;
        logic [3:0]         be;
        logic               misal;
        op   = alu_op_t'(ins.uop[3:0]);
        b    = ins.uop[4] ? ins.imm : ins.rk_data;
        addr = ins.rj_data + ins.imm;
        prod = $signed({{32{ins.rj_data[31]}}, ins.rj_data}) * $signed({{32{b[31]}}, b});
        case (op)
            alu_add:    w.data = ins.rj_data + b;
            alu_sub:    w.data = ins.rj_data - b;
            alu_and:    w.data = ins.rj_data & b;
            alu_or:     w.data = ins.rj_data | b;
            alu_xor:    w.data = ins.rj_data ^ b;
            alu_sll:    w.data = ins.rj_data << b[4:0];
            alu_srl:    w.data = ins.rj_data >> b[4:0];
            alu_slt:    w.data = {31'b0, $signed(ins.rj_data) < $signed(b)};
            alu_mul_lo: w.data = prod[31:0];
            alu_mul_hi: w.data = prod[63:32];
            default:    w.data = '0;
        endcase
        be    = (ins.uop[7:6] == mem_byte) ? 4'b0001 :
                (ins.uop[7:6] == mem_half) ? 4'b0011 : 4'b1111;
        misal = ins.uop[4] && ((ins.uop[7:6] == mem_half && addr[0]) ||
                               (ins.uop[7:6] == mem_word && addr[1:0] != 2'b00));
        w.trap  = (ins.trap != trap_none) ? ins.trap :
                  ins.uop[9] ? trap_syscall : ins.uop[10] ? trap_brk :
                  misal ? trap_misalign : trap_none;
        w.pc    = ins.pc;
        w.rd    = ins.rd;
        w.wb_en = ins.uop[11] & (w.trap == trap_none);
        r.op      = ins.uop[5];
        r.byte_en = be << addr[1:0];
        r.atomic  = ins.uop[8];
        r.addr    = addr;
    endtask

    task automatic check_wb(input wb_t got, input wb_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s wb got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_dcache(input dcache_req_t got, input dcache_req_t exp,
                                input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s dcache got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // present one instruction and wait until the stage takes it
    task automatic send(input issue_t ins);
        @(posedge clk);
        #1;
        issue       = ins;
        issue_valid = 1'b1;
        @(negedge clk);
        while (!issue_allowin) @(negedge clk);
        req_seen       = dcache_req;
        req_valid_seen = dcache_valid;
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        #1;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    task automatic run_and_check(input issue_t ins, input string what);
        wb_t         exp_wb;
        dcache_req_t exp_req;
        model(ins, exp_wb, exp_req);
        send(ins);
        check_flag(req_valid_seen, ins.uop[4], {what, " dcache_valid"});
        if (ins.uop[4]) begin
            check_dcache(req_seen, exp_req, what);
        end
        @(negedge clk);
        check_flag(wb_valid, 1'b1, {what, " wb_valid"});
        check_wb(wb, exp_wb, what);
        // stage stays blocked behind a trap
        if (exp_wb.trap != trap_none) begin
            pulse_flush();
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s done, %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic test_alu();
        logic [31:0] r;
        for (int i = 0; i < 16; i++) begin
            r = rand32();
            run_and_check(make_issue(make_uop(alu_op_t'({1'b0, r[2:0]}), 1'b0, 1'b0, mem_word,
                                              1'b0, 1'b0, 1'b0, 1'b1),
                                     rand32(), rand32(), rand32()), "alu");
        end
    endtask

    task automatic test_mul();
        word_t   a;
        word_t   b;
        alu_op_t op;
        for (int i = 0; i < 12; i++) begin
            a = rand32();
            b = rand32();
            // walk through every sign pairing
            a[31] = i[0];
            b[31] = i[1];
            op    = i[2] ? alu_mul_hi : alu_mul_lo;
            run_and_check(make_issue(make_uop(op, 1'b0, 1'b0, mem_word, 1'b0, 1'b0, 1'b0, 1'b1),
                                     a, b, rand32()), "mul");
        end
    endtask

    task automatic test_mem();
        mem_size_t size;
        for (int i = 0; i < 9; i++) begin
            size = (i % 3 == 0) ? mem_byte : (i % 3 == 1) ? mem_half : mem_word;
            // low address bits follow i to mix aligned and misaligned accesses
            run_and_check(make_issue(make_uop(alu_add, 1'b1, i[0], size, i[2], 1'b0, 1'b0, ~i[0]),
                                     rand32() & 32'hffff_fff0, rand32(),
                                     (rand32() & 32'h0000_fff0) | {30'b0, i[1:0]}), "mem");
        end
    endtask

    task automatic test_backpressure();
        issue_t      first;
        issue_t      second;
        wb_t         exp_first;
        wb_t         exp_second;
        dcache_req_t unused_req;
        first  = make_issue(make_uop(alu_xor, 1'b0, 1'b0, mem_word, 1'b0, 1'b0, 1'b0, 1'b1),
                            rand32(), rand32(), rand32());
        second = make_issue(make_uop(alu_sub, 1'b0, 1'b0, mem_word, 1'b0, 1'b0, 1'b0, 1'b1),
                            rand32(), rand32(), rand32());
        model(first, exp_first, unused_req);
        model(second, exp_second, unused_req);
        @(posedge clk);
        #1;
        wb_allowin = 1'b0;
        send(first);
        issue       = second;
        issue_valid = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_flag(wb_valid, 1'b1, "stall wb_valid");
            check_flag(issue_allowin, 1'b0, "stall issue_allowin");
            check_wb(wb, exp_first, "stall");
        end
        @(posedge clk);
        #1;
        wb_allowin = 1'b1;
        @(negedge clk);
        check_flag(issue_allowin, 1'b1, "release issue_allowin");
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
        @(negedge clk);
        check_flag(wb_valid, 1'b1, "after stall wb_valid");
        check_wb(wb, exp_second, "after stall");
    endtask

    task automatic test_trap_hold();
        issue_t      trapped;
        issue_t      later;
        wb_t         exp_trap;
        dcache_req_t unused_req;
        trapped = make_issue(make_uop(alu_add, 1'b0, 1'b0, mem_word, 1'b0, 1'b1, 1'b0, 1'b1),
                             rand32(), rand32(), rand32());
        later   = make_issue(make_uop(alu_or, 1'b0, 1'b0, mem_word, 1'b0, 1'b0, 1'b0, 1'b1),
                             rand32(), rand32(), rand32());
        model(trapped, exp_trap, unused_req);
        send(trapped);
        @(negedge clk);
        check_flag(wb_valid, 1'b1, "syscall wb_valid");
        check_wb(wb, exp_trap, "syscall");
        @(posedge clk);
        #1;
        issue       = later;
        issue_valid = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_flag(wb_valid, 1'b0, "held wb_valid");
            check_flag(issue_allowin, 1'b0, "held issue_allowin");
        end
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
        flush       = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        @(negedge clk);
        check_flag(issue_allowin, 1'b1, "flushed issue_allowin");
        run_and_check(later, "after flush");
    endtask

    task automatic test_flush_priority();
        issue_t victim;
        issue_t intruder;
        victim   = make_issue(make_uop(alu_and, 1'b0, 1'b0, mem_word, 1'b0, 1'b0, 1'b0, 1'b1),
                              rand32(), rand32(), rand32());
        intruder = make_issue(make_uop(alu_add, 1'b0, 1'b0, mem_word, 1'b0, 1'b0, 1'b0, 1'b1),
                              rand32(), rand32(), rand32());
        send(victim);
        flush       = 1'b1;
        issue       = intruder;
        issue_valid = 1'b1;
        @(negedge clk);
        check_flag(issue_allowin, 1'b1, "flush cycle issue_allowin");
        @(posedge clk);
        #1;
        flush       = 1'b0;
        issue_valid = 1'b0;
        @(negedge clk);
        check_flag(wb_valid, 1'b0, "after flush wb_valid");
    endtask

    initial begin
        rng         = 32'hb8af_9010;
        aresetn     = 1'b0;
        flush       = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        wb_allowin  = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        aresetn = 1'b1;
        @(negedge clk);
        check_flag(wb_valid, 1'b0, "reset wb_valid");
        check_flag(dcache_valid, 1'b0, "reset dcache_valid");
        check_flag(issue_allowin, 1'b1, "reset issue_allowin");
        end_test("reset");
        test_alu();
        end_test("alu");
        test_mul();
        end_test("mul");
        test_mem();
        end_test("mem");
        test_backpressure();
        end_test("backpressure");
        test_trap_hold();
        end_test("trap_hold");
        test_flush_priority();
        end_test("flush_priority");
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
isa_pkg.sv
pipe_pkg.sv
exe_decode.sv
exe_stage0.sv
exe_stage_buffer.sv
exe_result.sv
exe_top.sv
tb_exe_top.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --timing --timescale 1ns/1ps
TOP       := tb_exe_top
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
